//--- verilog/bwc_pkg.sv
package bwc_pkg;

    // ================================================
    // Data path widths
    // ================================================
    localparam int in_width    = 64;                     // Input data word
    localparam int out_width   = 128;                    // Output data word
    localparam int cache_width = in_width + out_width;   // Packing register size

    // Bit count arithmetic, wide enough for count + in_bw and cache + out_bw
    localparam int cnt_w = $clog2(cache_width + out_width + 1);

    // ================================================
    // Input FIFO sizing
    // ================================================
    localparam int fifo_depth = 4;                            // Entries
    localparam int fifo_ptr_w = $clog2(fifo_depth);           // Read/write pointer
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);       // Occupancy 0..depth

    // ================================================
    // Valid-bit counts and beats
    // ================================================
    typedef logic [$clog2(in_width):0]  in_bw_t;   // 0..64
    typedef logic [$clog2(out_width):0] out_bw_t;  // 0..128

    // Transfer configuration
    typedef struct packed {
        in_bw_t  in_bw;   // Valid bits per input word
        out_bw_t out_bw;  // Valid bits per output word
    } bwc_cfg_t;

    // One input word
    typedef struct packed {
        logic [in_width-1:0] dat;
        logic                last;  // Final word of transfer
    } bwc_in_beat_t;

    // One output word
    typedef struct packed {
        logic [out_width-1:0] dat;
        logic                 last;  // Final word of transfer
        out_bw_t              cnt;   // Valid bits in dat
    } bwc_out_beat_t;

endpackage

//--- verilog/bwc_cfg.sv
`timescale 1ns/10ps

// Transfer configuration holder and busy tracking
module bwc_cfg (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              start,     // One-cycle strobe
    input  bwc_pkg::bwc_cfg_t cfg,       // Level sampled on accepted start
    input  logic              out_done,  // Last output beat accepted
    output bwc_pkg::bwc_cfg_t cur_cfg,   // Widths of running transfer
    output logic              flush,     // Clears FIFO and core
    output logic              busy
);

    // ================================================
    // Start acceptance
    // ================================================
    logic start_ok;

    assign start_ok = start & ~busy;  // Ignored mid-transfer

    // ================================================
    // Control registers
    // ================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            busy  <= 1'b0;
            flush <= 1'b0;
        end else begin
            flush <= start_ok;               // Single pulse after start
            if (start_ok) begin
                busy <= 1'b1;
            end else if (out_done) begin
                busy <= 1'b0;                // Falls one cycle after last out
            end
        end
    end

    // Widths held for the whole transfer
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            cur_cfg <= '0;
        end else if (start_ok) begin
            cur_cfg <= cfg;                  // Capture on accepted start only
        end
    end

endmodule

//--- verilog/bwc_in_fifo.sv
`timescale 1ns/10ps

// First-word-fall-through buffer for input beats
module bwc_in_fifo (
    input  logic                  CLK,
    input  logic                  RST_N,
    input  logic                  flush,    // Drop stored beats
    input  logic                  wr_vld,
    input  bwc_pkg::bwc_in_beat_t wr_beat,
    output logic                  wr_rdy,
    output logic                  rd_vld,
    output bwc_pkg::bwc_in_beat_t rd_beat,
    input  logic                  rd_rdy
);

    // ================================================
    // Storage and pointers
    // ================================================
    bwc_pkg::bwc_in_beat_t           mem [bwc_pkg::fifo_depth];  // Beat array
    logic [bwc_pkg::fifo_ptr_w-1:0]  wr_ptr;
    logic [bwc_pkg::fifo_ptr_w-1:0]  rd_ptr;
    logic [bwc_pkg::fifo_ptr_w-1:0]  wr_addr;  // Write slot, zero on flush
    logic [bwc_pkg::fifo_cnt_w-1:0]  count;    // Occupancy
    logic                            wr_fire;
    logic                            rd_fire;

    // Wrap at depth, also for non power of two depths
    function automatic logic [bwc_pkg::fifo_ptr_w-1:0] ptr_inc(
        input logic [bwc_pkg::fifo_ptr_w-1:0] p
    );
        if (p == bwc_pkg::fifo_ptr_w'(bwc_pkg::fifo_depth - 1)) begin
            ptr_inc = '0;
        end else begin
            ptr_inc = p + 1'b1;
        end
    endfunction

    // ================================================
    // Handshake
    // ================================================
    assign wr_rdy  = (count != bwc_pkg::fifo_cnt_w'(bwc_pkg::fifo_depth));  // Not full
    assign rd_vld  = (count != '0);                                      // Not empty
    assign wr_fire = wr_vld & wr_rdy;
    assign rd_fire = rd_vld & rd_rdy;
    assign wr_addr = flush ? '0 : wr_ptr;  // Write during flush restarts at slot 0

    assign rd_beat = mem[rd_ptr];          // Head entry, straight from storage

    // ================================================
    // Pointer and occupancy update
    // ================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Stale beats dropped, concurrent write kept
            rd_ptr <= '0;
            wr_ptr <= wr_fire ? ptr_inc('0) : '0;
            count  <= wr_fire ? bwc_pkg::fifo_cnt_w'(1) : '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;  // Push only
                2'b01:   count <= count - 1'b1;  // Pop only
                default: count <= count;         // Both or neither
            endcase
        end
    end

    // Beat storage
    always_ff @(posedge CLK) begin
        if (wr_fire) begin
            mem[wr_addr] <= wr_beat;
        end
    end

endmodule

//--- verilog/bwc_core.sv
`timescale 1ns/10ps

// Bit packing register between variable-width input and output words
module bwc_core (
    input  logic                   CLK,
    input  logic                   RST_N,
    input  logic                   flush,     // Empty the register
    input  bwc_pkg::bwc_cfg_t      cfg,       // in_bw and out_bw
    input  logic                   in_vld,
    input  bwc_pkg::bwc_in_beat_t  in_beat,
    output logic                   in_rdy,
    output logic                   out_vld,
    output bwc_pkg::bwc_out_beat_t out_beat,
    input  logic                   out_rdy,
    output logic                   out_done   // Last output beat accepted
);

    // ================================================
    // State
    // ================================================
    // Bits at and above count are always zero, so insertion is a plain OR
    logic [bwc_pkg::cache_width-1:0] serial;      // Packed bit stream, LSB first
    logic [bwc_pkg::cnt_w-1:0]       count;       // Stored bits
    logic                            last;        // Last input word stored

    // ================================================
    // Next-state signals
    // ================================================
    logic                            in_fire;
    logic                            out_fire;
    logic [bwc_pkg::cnt_w-1:0]       in_bits;     // in_bw, widened
    logic [bwc_pkg::cnt_w-1:0]       out_bits;    // out_bw, widened
    logic [bwc_pkg::cnt_w-1:0]       cnt_fill;    // count + in_bits
    logic                            fit_now;
    logic                            fit_after;
    logic [bwc_pkg::cnt_w-1:0]       cnt_drain;   // Count after output shift
    logic [bwc_pkg::cnt_w-1:0]       cnt_next;
    logic [bwc_pkg::in_width-1:0]    in_dat_m;    // Input bits above in_bw cleared
    logic [bwc_pkg::cache_width-1:0] in_ext;
    logic [bwc_pkg::cache_width-1:0] serial_base; // Serial after output shift
    logic [bwc_pkg::cache_width-1:0] serial_next;
    logic [bwc_pkg::out_width-1:0]   out_mask;

    assign in_bits  = bwc_pkg::cnt_w'(cfg.in_bw);
    assign out_bits = bwc_pkg::cnt_w'(cfg.out_bw);

    // ================================================
    // Output side
    // ================================================
    // Full word, or the tail once the last input is in
    assign out_vld  = (count != '0) & ((count >= out_bits) | last);
    assign out_fire = out_vld & out_rdy;
    assign out_done = out_fire & out_beat.last;

    assign out_mask      = ~({bwc_pkg::out_width{1'b1}} << cfg.out_bw);  // Low out_bw ones
    assign out_beat.dat  = serial[bwc_pkg::out_width-1:0] & out_mask;
    assign out_beat.last = last & (count <= out_bits);               // Nothing left after
    assign out_beat.cnt  = (count < out_bits) ? bwc_pkg::out_bw_t'(count) : cfg.out_bw;

    // ================================================
    // Input side
    // ================================================
    assign cnt_fill  = count + in_bits;
    assign fit_now   = cnt_fill <= bwc_pkg::cnt_w'(bwc_pkg::cache_width);
    // Room made by an output leaving in the same cycle
    assign fit_after = out_fire
                       & (cnt_fill <= bwc_pkg::cnt_w'(bwc_pkg::cache_width) + out_bits);
    assign in_rdy    = fit_now | fit_after;
    assign in_fire   = in_vld & in_rdy;

    assign in_dat_m = in_beat.dat & ~({bwc_pkg::in_width{1'b1}} << cfg.in_bw);
    assign in_ext   = {{(bwc_pkg::cache_width - bwc_pkg::in_width){1'b0}}, in_dat_m};

    // ================================================
    // Shift, then insert at the drained count
    // ================================================
    always_comb begin
        if (out_fire) begin
            serial_base = serial >> cfg.out_bw;                          // Drop sent bits
            cnt_drain   = (count > out_bits) ? count - out_bits : '0;    // Tail clamps to 0
        end else begin
            serial_base = serial;
            cnt_drain   = count;
        end

        if (in_fire) begin
            serial_next = serial_base | (in_ext << cnt_drain);           // Append above data
            cnt_next    = cnt_drain + in_bits;
        end else begin
            serial_next = serial_base;
            cnt_next    = cnt_drain;
        end
    end

    // ================================================
    // Registers
    // ================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            serial <= '0;
            count  <= '0;
            last   <= 1'b0;
        end else if (flush) begin
            serial <= '0;                    // Restores zero-above-count
            count  <= '0;
            last   <= 1'b0;
        end else begin
            serial <= serial_next;
            count  <= cnt_next;
            if (in_fire) begin
                last <= in_beat.last;
            end
        end
    end

endmodule

//--- verilog/bwc_top.sv
`timescale 1ns/10ps

// Stream bit-width converter, top level
module bwc_top (
    input  logic                   CLK,
    input  logic                   RST_N,

    // Configuration
    input  logic                   start,    // Strobe, taken when idle
    input  bwc_pkg::bwc_cfg_t      cfg,

    // Input stream
    input  logic                   in_vld,
    input  bwc_pkg::bwc_in_beat_t  in_beat,
    output logic                   in_rdy,

    // Output stream
    output logic                   out_vld,
    output bwc_pkg::bwc_out_beat_t out_beat,
    input  logic                   out_rdy,

    output logic                   busy      // Transfer in flight
);

    // ================================================
    // Internal wires
    // ================================================
    bwc_pkg::bwc_cfg_t     cur_cfg;    // Widths of running transfer
    logic                  flush;      // Start-of-transfer clear
    logic                  out_done;   // Last output accepted
    logic                  fifo_vld;
    bwc_pkg::bwc_in_beat_t fifo_beat;
    logic                  fifo_rdy;   // Core room for next word

    // ================================================
    // Configuration block
    // ================================================
    bwc_cfg i_cfg (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .start    (start),
        .cfg      (cfg),
        .out_done (out_done),
        .cur_cfg  (cur_cfg),
        .flush    (flush),
        .busy     (busy)
    );

    // Input buffer
    bwc_in_fifo i_fifo (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .flush   (flush),
        .wr_vld  (in_vld),
        .wr_beat (in_beat),
        .wr_rdy  (in_rdy),
        .rd_vld  (fifo_vld),
        .rd_beat (fifo_beat),
        .rd_rdy  (fifo_rdy)
    );

    // Packing core
    bwc_core i_core (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .flush    (flush),
        .cfg      (cur_cfg),
        .in_vld   (fifo_vld),
        .in_beat  (fifo_beat),
        .in_rdy   (fifo_rdy),
        .out_vld  (out_vld),
        .out_beat (out_beat),
        .out_rdy  (out_rdy),
        .out_done (out_done)
    );

endmodule

//--- test/tb_bwc_top.sv
`timescale 1ns/10ps

module tb_bwc_top;

    // ================================================
    // DUT signals
    // ================================================
    logic                   CLK;
    logic                   RST_N;
    logic                   start;
    bwc_pkg::bwc_cfg_t      cfg;
    logic                   in_vld;
    bwc_pkg::bwc_in_beat_t  in_beat;
    logic                   in_rdy;
    logic                   out_vld;
    bwc_pkg::bwc_out_beat_t out_beat;
    logic                   out_rdy;
    logic                   busy;

    // ================================================
    // Bench state
    // ================================================
    bit                     ref_q[$];         // Expected bit stream from LSB up
    int                     exp_in_bw;        // Widths of accepted start
    int                     exp_out_bw;
    int                     total_bits;       // Bits in current transfer
    int                     sent_bits;        // Bits already seen at output
    int                     err_cnt;
    int                     test_err;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     wait_limit;       // Cycles per wait loop
    int                     rdy_mode;         // 0 for always ready and 1 for random
    int                     stall_left;       // Forced out_rdy low cycles
    bit                     saw_full;         // in_rdy seen low during transfer
    bit                     hold_pending;     // Output stalled last edge
    bit                     timed_out;        // A wait loop ran out
    bwc_pkg::bwc_out_beat_t held_beat;

    bwc_top i_bwc_top (
        .CLK      (CLK),
        .RST_N    (RST_N),
        .start    (start),
        .cfg      (cfg),
        .in_vld   (in_vld),
        .in_beat  (in_beat),
        .in_rdy   (in_rdy),
        .out_vld  (out_vld),
        .out_beat (out_beat),
        .out_rdy  (out_rdy),
        .busy     (busy)
    );

    always #50 CLK = ~CLK;  // 100 ns period

    // Output ready pattern
    always @(posedge CLK) begin
        if (stall_left > 0) begin
            out_rdy    <= 1'b0;
            stall_left <= stall_left - 1;
        end else if (rdy_mode == 1) begin
            out_rdy <= (($urandom % 3) != 0);  // Ready two cycles in three
        end else begin
            out_rdy <= 1'b1;
        end
    end

    // ================================================
    // Reporting helpers
    // ================================================
    task automatic note_error(input string msg);
        $display("FAILED t=%0t: %s", $time, msg);
        err_cnt++;
        test_err++;
    endtask

    task automatic close_test(input string name);
        if (timed_out) begin
            $display("%s: FAILED, stopped by timeout", name);
            fail_cnt++;
        end else if (test_err == 0) begin
            $display("%s: PASSED", name);
            pass_cnt++;
        end else begin
            $display("%s: FAILED with %0d errors", name, test_err);
            fail_cnt++;
        end
        test_err = 0;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s at t=%0t", what, $time);
        timed_out = 1'b1;
        err_cnt++;
        test_err++;
    endtask

    // ================================================
    // Stream model and output checks
    // ================================================
    task automatic check_out_beat(input bwc_pkg::bwc_out_beat_t b);
        int                           exp_cnt;
        bit                           exp_last;
        logic [bwc_pkg::out_width-1:0] exp_dat;
        exp_cnt = total_bits - sent_bits;
        if (exp_cnt > exp_out_bw) begin
            exp_cnt = exp_out_bw;                  // Full word unless tail
        end
        exp_last = (sent_bits + exp_cnt == total_bits);
        exp_dat  = '0;                             // Zeros above cnt
        for (int i = 0; i < exp_cnt; i++) begin
            if (ref_q.size() > 0) begin
                exp_dat[i] = ref_q.pop_front();
            end
        end
        assert (b.cnt == exp_cnt)
            else note_error($sformatf("cnt %0d, expected %0d", b.cnt, exp_cnt));
        assert (b.last == exp_last)
            else note_error($sformatf("last %0b, expected %0b", b.last, exp_last));
        assert (b.dat == exp_dat)
            else note_error($sformatf("dat %h, expected %h", b.dat, exp_dat));
        sent_bits += exp_cnt;
    endtask

    always @(posedge CLK) begin
        if (RST_N) begin
            if (in_vld && in_rdy) begin
                for (int i = 0; i < exp_in_bw; i++) begin
                    ref_q.push_back(in_beat.dat[i]);   // Only valid bits enter stream
                end
            end
            if (busy && !in_rdy) begin
                saw_full = 1'b1;
            end
            if (hold_pending) begin
                assert (out_vld && (out_beat == held_beat))
                    else note_error("output beat changed while stalled");
            end
            if (out_vld && out_rdy) begin
                check_out_beat(out_beat);
            end
            hold_pending = out_vld && !out_rdy;
            held_beat    = out_beat;
        end
    end

    // ================================================
    // Stimulus tasks
    // ================================================
    task automatic start_transfer(input int ibw, input int obw);
        int n;
        if (timed_out) begin
            return;
        end
        @(posedge CLK);
        start      <= 1'b1;
        cfg.in_bw  <= bwc_pkg::in_bw_t'(ibw);
        cfg.out_bw <= bwc_pkg::out_bw_t'(obw);
        @(posedge CLK);
        start <= 1'b0;
        n = 0;
        while (!busy && n < wait_limit) begin
            @(posedge CLK);
            n++;
        end
        if (!busy) begin
            report_timeout("busy after start");
            return;
        end
        exp_in_bw  = ibw;                          // Model follows accepted start
        exp_out_bw = obw;
        sent_bits  = 0;
        total_bits = 0;
        ref_q.delete();
        repeat (2) @(posedge CLK);                 // Flush settles
    endtask

    task automatic send_words(input int nwords);
        int                    n;
        bwc_pkg::bwc_in_beat_t b;
        if (timed_out) begin
            return;
        end
        for (int w = 0; w < nwords; w++) begin
            b.dat   = {$urandom, $urandom};
            b.last  = (w == nwords - 1);
            in_vld  <= 1'b1;
            in_beat <= b;
            n = 0;
            do begin
                @(posedge CLK);
                n++;
            end while (!in_rdy && n < wait_limit);
            if (!in_rdy) begin
                report_timeout("input acceptance");
                break;
            end
        end
        in_vld <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        if (timed_out) begin
            return;
        end
        n = 0;
        while (busy && n < wait_limit) begin
            @(posedge CLK);
            n++;
        end
        if (busy) begin
            report_timeout("end of transfer");
            return;
        end
        assert (ref_q.size() == 0 && sent_bits == total_bits)
            else note_error($sformatf("%0d bits left in stream", ref_q.size()));
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        void'($urandom(32'he526));
        CLK        = 1'b0;
        RST_N      = 1'b0;
        start      = 1'b0;
        cfg        = '0;
        in_vld     = 1'b0;
        in_beat    = '0;
        out_rdy    = 1'b1;
        rdy_mode   = 0;
        stall_left = 0;
        wait_limit = 1000;
        err_cnt    = 0;
        test_err   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        saw_full   = 1'b0;
        timed_out  = 1'b0;
        exp_in_bw  = 0;
        exp_out_bw = 0;
        repeat (10) @(posedge CLK);
        RST_N <= 1'b1;
        @(posedge CLK);

        // Reset state then start
        assert (!out_vld && !busy && in_rdy) else note_error("wrong state after reset");
        start_transfer(64, 128);
        assert (busy) else note_error("busy low after start");
        close_test("test 1 reset and start");

        // Widening with two inputs per output
        total_bits = 6 * 64;
        send_words(6);
        wait_idle();
        close_test("test 2 widening 64 to 128");

        // Widths that do not divide
        start_transfer(24, 40);
        total_bits = 7 * 24;                       // Leaves an 8 bit tail
        send_words(7);
        wait_idle();
        close_test("test 3 widths 24 to 40");

        // Narrowing under back-pressure
        saw_full = 1'b0;
        start_transfer(64, 16);
        total_bits = 12 * 64;
        stall_left <= 40;
        rdy_mode   <= 1;
        send_words(12);
        wait_idle();
        rdy_mode <= 0;
        assert (saw_full) else note_error("in_rdy never fell while output stalled");
        close_test("test 4 narrowing 64 to 16");

        // Start while busy is ignored
        start_transfer(16, 48);
        start      <= 1'b1;
        cfg.in_bw  <= bwc_pkg::in_bw_t'(8);
        cfg.out_bw <= bwc_pkg::out_bw_t'(8);
        @(posedge CLK);
        start <= 1'b0;
        @(posedge CLK);
        assert (busy) else note_error("busy dropped after start while busy");
        total_bits = 9 * 16;
        send_words(9);
        wait_idle();
        start_transfer(40, 24);                    // New widths after idle
        total_bits = 5 * 40;
        send_words(5);
        wait_idle();
        close_test("test 5 start while busy");

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/bwc_pkg.sv
verilog/bwc_cfg.sv
verilog/bwc_in_fifo.sv
verilog/bwc_core.sv
verilog/bwc_top.sv
test/tb_bwc_top.sv

//--- Bender.yml
package:
  name: bwc

sources:
  - verilog/bwc_pkg.sv
  - verilog/bwc_cfg.sv
  - verilog/bwc_in_fifo.sv
  - verilog/bwc_core.sv
  - verilog/bwc_top.sv
  - target: test
    files:
      - test/tb_bwc_top.sv
